/* lut_cache.f */
logic/lut_cache_pkg.sv
logic/lutram_array.sv
logic/hit_merge.sv
logic/axil_front.sv
logic/lut_cache_top.sv
verif/lut_cache_tb.sv

/* Makefile */
TOP := lut_cache_tb

sim:
	verilator --binary --timing -sv -f lut_cache.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* verif/lut_cache_tb.sv */
`timescale 1ns/1ps

module lut_cache_tb;

    localparam int NUM_SETS   = 16;
    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS   = 32 - 2 - INDEX_BITS;
    localparam int TIMEOUT    = 40;                     // Cycles per wait

    logic        clk_in;
    logic        reset_in;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    int          errors;
    int          checks;
    logic [31:0] rng_state;

    // Reference model, one entry per set
    logic                model_valid [NUM_SETS];
    logic [TAG_BITS-1:0] model_tag   [NUM_SETS];
    logic [7:0]          model_bytes [NUM_SETS][4];

    lut_cache_top #(.NUM_SETS(NUM_SETS)) i_dut (.*);

    always #4 clk_in = ~clk_in;

    // ======================================================================
    // Random numbers and model
    // ======================================================================

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        logic [INDEX_BITS-1:0] idx;
        idx = addr[2 +: INDEX_BITS];
        if (strb != 4'b0000)                            // Empty strobe touches nothing
        begin
            model_valid[idx] = 1'b1;
            model_tag[idx]   = addr[31 -: TAG_BITS];
        end
        for (int b = 0; b < 4; b++)
        begin
            if (strb[b])
                model_bytes[idx][b] = data[8*b +: 8];
        end
    endtask

    task automatic predict_read(input logic [31:0] addr, output logic [31:0] exp_data,
                                output logic [1:0] exp_resp);
        logic [INDEX_BITS-1:0] idx;
        idx = addr[2 +: INDEX_BITS];
        if (model_valid[idx] && (model_tag[idx] == addr[31 -: TAG_BITS]))
        begin
            exp_data = {model_bytes[idx][3], model_bytes[idx][2],
                        model_bytes[idx][1], model_bytes[idx][0]};
            exp_resp = lut_cache_pkg::RESP_OKAY;
        end
        else
        begin
            exp_data = 32'h0;
            exp_resp = lut_cache_pkg::RESP_SLVERR;
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("ERROR: timed out at %0t waiting for %s", $time, what);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Simulation FAILED");
        $finish;
    endtask

    // ======================================================================
    // Bus transactions
    // ======================================================================

    task automatic write_and_check(input logic [31:0] addr, input logic [31:0] data,
                                   input logic [3:0] strb);
        int          cycles;
        logic        done;
        logic [31:0] r;
        @(negedge clk_in);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        r       = next_random();
        bready  = r[0];
        cycles  = 0;
        do
        begin
            @(posedge clk_in);
            cycles++;
            if (awready != wready)
            begin
                errors++;
                $display("ERROR: write address and data handshakes split at %0t", $time);
            end
            if (arready)
            begin
                errors++;
                $display("FAIL at %0t: arready expected 0, got %b", $time, arready);
            end
            if (cycles > TIMEOUT)
                report_timeout("AWREADY and WREADY");
        end while (!(awready && wready));
        model_write(addr, data, strb);
        @(negedge clk_in);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        cycles  = 0;
        done    = 1'b0;
        while (!done)
        begin
            @(posedge clk_in);
            cycles++;
            checks++;
            if (!bvalid)                                // B held from the first cycle on
            begin
                errors++;
                $display("FAIL at %0t: bvalid expected 1, got %b", $time, bvalid);
            end
            if (rvalid)
            begin
                errors++;
                $display("FAIL at %0t: rvalid expected 0, got %b", $time, rvalid);
            end
            if (bresp != lut_cache_pkg::RESP_OKAY)
            begin
                errors++;
                $display("FAIL at %0t: bresp expected %b, got %b",
                         $time, lut_cache_pkg::RESP_OKAY, bresp);
            end
            done = bvalid && bready;
            if (!done)
            begin
                if (cycles > TIMEOUT)
                    report_timeout("BREADY to take the write response");
                @(negedge clk_in);
                r      = next_random();
                bready = r[0];
            end
        end
        @(posedge clk_in);
        if (bvalid || rvalid)
        begin
            errors++;
            $display("ERROR: extra response after a write at %0t", $time);
        end
    endtask

    task automatic read_and_check(input logic [31:0] addr);
        int          cycles;
        logic        done;
        logic [31:0] r;
        logic [31:0] exp_data;
        logic [1:0]  exp_resp;
        @(negedge clk_in);
        araddr  = addr;
        arvalid = 1'b1;
        r       = next_random();
        rready  = r[0];
        cycles  = 0;
        do
        begin
            @(posedge clk_in);
            cycles++;
            if (cycles > TIMEOUT)
                report_timeout("ARREADY");
        end while (!arready);
        predict_read(addr, exp_data, exp_resp);
        @(negedge clk_in);
        arvalid = 1'b0;
        cycles  = 0;
        done    = 1'b0;
        while (!done)
        begin
            @(posedge clk_in);
            cycles++;
            checks++;
            if (rvalid != (cycles >= 2))                // Two cycles after AR, then held
            begin
                errors++;
                $display("FAIL at %0t: rvalid expected %b, got %b (cycle %0d after AR)",
                         $time, cycles >= 2, rvalid, cycles);
            end
            if (bvalid)
            begin
                errors++;
                $display("FAIL at %0t: bvalid expected 0, got %b", $time, bvalid);
            end
            if (rvalid && rdata != exp_data)
            begin
                errors++;
                $display("FAIL at %0t: rdata expected %h, got %h", $time, exp_data, rdata);
            end
            if (rvalid && rresp != exp_resp)
            begin
                errors++;
                $display("FAIL at %0t: rresp expected %b, got %b", $time, exp_resp, rresp);
            end
            done = rvalid && rready;
            if (!done)
            begin
                if (cycles > TIMEOUT)
                    report_timeout("RREADY to take the read response");
                @(negedge clk_in);
                r      = next_random();
                rready = r[0];
            end
        end
        @(posedge clk_in);
        if (bvalid || rvalid)
        begin
            errors++;
            $display("ERROR: extra response after a read at %0t", $time);
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial
    begin
        logic [31:0]         r;
        logic [31:0]         a;
        logic [31:0]         b;
        logic [TAG_BITS-1:0] base_tag;
        clk_in    = 1'b0;
        reset_in  = 1'b1;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        errors    = 0;
        checks    = 0;
        rng_state = 32'h4256_5ed3;
        for (int i = 0; i < NUM_SETS; i++)
            model_valid[i] = 1'b0;
        repeat (10) @(posedge clk_in);
        if ({awready, wready, arready, bvalid, rvalid} != 5'b00000)
        begin
            errors++;
            $display("FAIL at %0t: {awready,wready,arready,bvalid,rvalid} expected 00000, got %b",
                     $time, {awready, wready, arready, bvalid, rvalid});
        end
        @(negedge clk_in);
        reset_in = 1'b0;

        for (int i = 0; i < 12; i++)                    // Cold cache misses
            read_and_check(next_random());
        for (int i = 0; i < 12; i++)                    // Full-word write, read back
        begin
            a = next_random();
            write_and_check(a, next_random(), 4'hf);
            read_and_check(a);
        end
        a = next_random();                              // Byte merging
        write_and_check(a, next_random(), 4'hf);
        for (int i = 0; i < 12; i++)
        begin
            r = next_random();
            write_and_check(a, next_random(), r[3:0]);
            read_and_check(a);
        end
        for (int i = 0; i < 6; i++)                     // Same set, other tag
        begin
            a = next_random();
            b = a ^ {{TAG_BITS{1'b1}}, {(INDEX_BITS + 2){1'b0}}};
            write_and_check(a, next_random(), 4'hf);
            read_and_check(b);
            write_and_check(b, next_random(), 4'hf);
            read_and_check(a);
            read_and_check(b);
        end
        base_tag = TAG_BITS'(next_random());            // Mixed traffic over few tags
        for (int i = 0; i < 300; i++)
        begin
            r = next_random();
            a = {base_tag ^ TAG_BITS'(r[5:4]), r[6 +: INDEX_BITS], r[11:10]};
            if (r[0])
                write_and_check(a, next_random(), r[15:12]);
            else
                read_and_check(a);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* logic/lut_cache_top.sv */
`timescale 1ns/1ps

module lut_cache_top
#(
    parameter int NUM_SETS = 16
)
(
    input  logic                                  clk_in,
    input  logic                                  reset_in,

    input  logic [lut_cache_pkg::ADDR_WIDTH-1:0]  awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [lut_cache_pkg::DATA_WIDTH-1:0]  wdata,
    input  logic [lut_cache_pkg::STRB_WIDTH-1:0]  wstrb,
    input  logic                                  wvalid,
    output logic                                  wready,
    output logic [1:0]                            bresp,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [lut_cache_pkg::ADDR_WIDTH-1:0]  araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [lut_cache_pkg::DATA_WIDTH-1:0]  rdata,
    output logic [1:0]                            rresp,
    output logic                                  rvalid,
    input  logic                                  rready
);

    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS   = lut_cache_pkg::ADDR_WIDTH - lut_cache_pkg::OFFSET_BITS
                                - INDEX_BITS;

    typedef logic [TAG_BITS-1:0] tag_t;

    logic                                 access_en;
    logic [INDEX_BITS-1:0]                index;
    tag_t                                 write_tag;
    logic                                 tag_write_en;
    logic [lut_cache_pkg::STRB_WIDTH-1:0] data_wstrb;
    lut_cache_pkg::data_t                 write_data;
    tag_t                                 lookup_tag;
    tag_t                                 stored_tag;
    logic                                 tag_valid;
    lut_cache_pkg::data_t                 stored_data;
    lut_cache_pkg::lookup_result_t        result;
    logic                                 result_valid;

    // ======================================================================
    // Host front end
    // ======================================================================

    axil_front #(.NUM_SETS(NUM_SETS), .tag_t(tag_t)) i_front (
        .clk_in,       .reset_in,
        .awaddr,       .awvalid,      .awready,
        .wdata,        .wstrb,        .wvalid,      .wready,
        .bresp,        .bvalid,       .bready,
        .araddr,       .arvalid,      .arready,
        .rdata,        .rresp,        .rvalid,      .rready,
        .access_en,    .index,        .write_tag,   .tag_write_en,
        .data_wstrb,   .write_data,   .lookup_tag,
        .result,       .result_valid
    );

    // ======================================================================
    // Tag and data arrays
    // ======================================================================

    lutram_array #(
        .entry_t(tag_t), .NUM_SETS(NUM_SETS), .NUM_LANES(1), .WITH_VALID(1'b1)
    ) i_tag_array (
        .clk_in, .reset_in, .access_en, .index,
        .lane_write_en (tag_write_en),              // Whole tag in one lane
        .write_entry   (write_tag),
        .read_entry    (stored_tag),
        .read_valid    (tag_valid)
    );

    lutram_array #(
        .entry_t(lut_cache_pkg::data_t), .NUM_SETS(NUM_SETS),
        .NUM_LANES(lut_cache_pkg::STRB_WIDTH), .WITH_VALID(1'b0)
    ) i_data_array (
        .clk_in, .reset_in, .access_en, .index,
        .lane_write_en (data_wstrb),
        .write_entry   (write_data),
        .read_entry    (stored_data),
        .read_valid    ()                           // Tag array owns validity
    );

    hit_merge #(.tag_t(tag_t)) i_hit_merge (
        .clk_in, .reset_in,
        .lookup_en (access_en),
        .lookup_tag, .stored_tag, .tag_valid, .stored_data,
        .result,     .result_valid
    );

endmodule

/* logic/axil_front.sv */
`timescale 1ns/1ps

module axil_front
#(
    parameter int  NUM_SETS = 16,
    parameter type tag_t    = logic [25:0]
)
(
    input  logic                                  clk_in,
    input  logic                                  reset_in,

    // AXI4-Lite slave
    input  logic [lut_cache_pkg::ADDR_WIDTH-1:0]  awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [lut_cache_pkg::DATA_WIDTH-1:0]  wdata,
    input  logic [lut_cache_pkg::STRB_WIDTH-1:0]  wstrb,
    input  logic                                  wvalid,
    output logic                                  wready,
    output logic [1:0]                            bresp,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [lut_cache_pkg::ADDR_WIDTH-1:0]  araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [lut_cache_pkg::DATA_WIDTH-1:0]  rdata,
    output logic [1:0]                            rresp,
    output logic                                  rvalid,
    input  logic                                  rready,

    // Array side
    output logic                                  access_en,
    output logic [$clog2(NUM_SETS)-1:0]           index,
    output tag_t                                  write_tag,
    output logic                                  tag_write_en,
    output logic [lut_cache_pkg::STRB_WIDTH-1:0]  data_wstrb,
    output lut_cache_pkg::data_t                  write_data,
    output tag_t                                  lookup_tag,
    input  lut_cache_pkg::lookup_result_t         result,
    input  logic                                  result_valid
);

    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS   = $bits(tag_t);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ_ACCESS,
        ST_READ_WAIT,
        ST_RESPOND
    } state_t;

    state_t                  state;
    state_t                  state_next;
    logic                    write_go;
    logic                    read_go;
    logic                    resp_is_read;              // RESPOND holds R, else B
    logic [INDEX_BITS-1:0]   read_index;
    tag_t                    read_tag;
    lut_cache_pkg::data_t    rdata_q;
    logic [1:0]              rresp_q;
    logic [1:0]              result_resp;

    // ======================================================================
    // Handshakes and array drive
    // ======================================================================

    assign write_go = (state == ST_IDLE) && awvalid && wvalid;
    assign read_go  = (state == ST_IDLE) && !(awvalid && wvalid) && arvalid;   // Writes first

    assign awready = write_go;
    assign wready  = write_go;
    assign arready = read_go;

    assign access_en    = (state == ST_READ_ACCESS);
    assign index        = write_go ? awaddr[lut_cache_pkg::OFFSET_BITS +: INDEX_BITS]
                                   : read_index;
    assign write_tag    = tag_t'(awaddr[lut_cache_pkg::ADDR_WIDTH-1 -: TAG_BITS]);
    assign tag_write_en = write_go && (|wstrb);
    assign data_wstrb   = write_go ? wstrb : '0;
    assign write_data   = wdata;
    assign lookup_tag   = read_tag;

    // ======================================================================
    // Responses
    // ======================================================================

    assign result_resp = result.hit ? lut_cache_pkg::RESP_OKAY : lut_cache_pkg::RESP_SLVERR;

    assign bvalid = (state == ST_RESPOND) && !resp_is_read;
    assign bresp  = lut_cache_pkg::RESP_OKAY;

    assign rvalid = ((state == ST_READ_WAIT) && result_valid) ||
                    ((state == ST_RESPOND) && resp_is_read);
    assign rdata  = (state == ST_RESPOND) ? rdata_q : result.data;
    assign rresp  = (state == ST_RESPOND) ? rresp_q : result_resp;

    // ======================================================================
    // State machine
    // ======================================================================

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
            begin
                if (write_go)
                    state_next = ST_RESPOND;
                else if (read_go)
                    state_next = ST_READ_ACCESS;
            end
            ST_READ_ACCESS:
            begin
                state_next = ST_READ_WAIT;
            end
            ST_READ_WAIT:
            begin
                if (result_valid)
                    state_next = rready ? ST_IDLE : ST_RESPOND;
            end
            default:
            begin
                if (resp_is_read ? rready : bready)
                    state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state        <= ST_IDLE;
            resp_is_read <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (write_go)
                resp_is_read <= 1'b0;
            else if (state == ST_READ_WAIT)
                resp_is_read <= 1'b1;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (read_go)
        begin
            read_index <= araddr[lut_cache_pkg::OFFSET_BITS +: INDEX_BITS];
            read_tag   <= tag_t'(araddr[lut_cache_pkg::ADDR_WIDTH-1 -: TAG_BITS]);
        end
        if ((state == ST_READ_WAIT) && result_valid)
        begin
            rdata_q <= result.data;                     // Held while R is stalled
            rresp_q <= result_resp;
        end
    end

endmodule

/* logic/hit_merge.sv */
`timescale 1ns/1ps

module hit_merge
#(
    parameter type tag_t = logic [25:0]
)
(
    input  logic                        clk_in,
    input  logic                        reset_in,

    input  logic                        lookup_en,
    input  tag_t                        lookup_tag,
    input  tag_t                        stored_tag,
    input  logic                        tag_valid,
    input  lut_cache_pkg::data_t        stored_data,

    output lut_cache_pkg::lookup_result_t result,
    output logic                        result_valid
);

    logic                 tag_match_q;
    lut_cache_pkg::data_t data_q;
    logic                 hit;

    // ======================================================================
    // Lookup stage
    // ======================================================================

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= lookup_en;                  // One cycle per lookup
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (lookup_en)
        begin
            tag_match_q <= (stored_tag == lookup_tag);
            data_q      <= stored_data;                 // Raw word, masked later
        end
    end

    // ======================================================================
    // Result
    // ======================================================================

    // Valid bit from the tag array lands in the same cycle as tag_match_q
    assign hit = tag_match_q && tag_valid;

    assign result.hit  = hit;
    assign result.data = hit ? data_q : '0;

endmodule

/* logic/lutram_array.sv */
`timescale 1ns/1ps

module lutram_array
#(
    parameter type entry_t    = logic [31:0],
    parameter int  NUM_SETS   = 16,
    parameter int  NUM_LANES  = 4,
    parameter bit  WITH_VALID = 1'b1
)
(
    input  logic                        clk_in,
    input  logic                        reset_in,

    input  logic                        access_en,
    input  logic [NUM_LANES-1:0]        lane_write_en,
    input  logic [$clog2(NUM_SETS)-1:0] index,

    input  entry_t                      write_entry,
    output entry_t                      read_entry,
    output logic                        read_valid
);

    localparam int ENTRY_BITS = $bits(entry_t);
    localparam int LANE_BITS  = ENTRY_BITS / NUM_LANES;

    logic [ENTRY_BITS-1:0] ram [NUM_SETS];              // Distributed RAM
    logic [ENTRY_BITS-1:0] write_bits;

    assign write_bits = write_entry;

    // ======================================================================
    // Per-set valid bits
    // ======================================================================

    generate
        if (WITH_VALID)
        begin : g_valid
            logic [NUM_SETS-1:0] valid_bits;

            always_ff @(posedge clk_in or posedge reset_in)
            begin
                if (reset_in)
                begin
                    valid_bits <= '0;
                    read_valid <= 1'b0;
                end
                else
                begin
                    if (|lane_write_en)
                    begin
                        valid_bits[index] <= 1'b1;      // Any lane write validates
                    end
                    read_valid <= access_en && valid_bits[index];
                end
            end
        end
        else
        begin : g_no_valid
            assign read_valid = 1'b1;                   // Every set counts as valid
        end
    endgenerate

    // ======================================================================
    // Lane writes and read port
    // ======================================================================

    always_ff @(posedge clk_in)
    begin
        for (int lane = 0; lane < NUM_LANES; lane++)
        begin
            if (lane_write_en[lane])
            begin
                ram[index][lane*LANE_BITS +: LANE_BITS] <=
                    write_bits[lane*LANE_BITS +: LANE_BITS];
            end
        end
    end

    assign read_entry = entry_t'(access_en ? ram[index] : '0);

endmodule

/* logic/lut_cache_pkg.sv */
package lut_cache_pkg;

    // ======================================================================
    // Bus and word geometry
    // ======================================================================

    localparam int ADDR_WIDTH  = 32;                   // Host byte address
    localparam int DATA_WIDTH  = 32;                   // Host data word
    localparam int BYTE_LEN    = 8;                    // Bits per write lane
    localparam int STRB_WIDTH  = DATA_WIDTH / BYTE_LEN;
    localparam int OFFSET_BITS = 2;                    // Byte offset in a word

    // ======================================================================
    // AXI response codes
    // ======================================================================

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // ======================================================================
    // Shared types
    // ======================================================================

    typedef logic [DATA_WIDTH-1:0] data_t;

    // Merged answer of one read lookup
    typedef struct packed {
        logic  hit;                                    // Valid set and tag match
        data_t data;                                   // Zero on a miss
    } lookup_result_t;

endpackage
